// ==== intra16_cost.sv ====
// Intra 16x16 cost unit that sums absolute coefficients per mode and keeps the cheapest mode
`timescale 1ns/1ns

module intra16_cost (
	input  logic                  clk,
	input  logic                  rst_n,
	input  intra_pkg::blk_req_t   req_i,
	input  logic                  avail_t_i,
	input  logic                  avail_l_i,
	input  intra_pkg::coef_blk_t  coef_i,
	output intra_pkg::pred_mode_t mode_o,
	output intra_pkg::mb_cost_t   cost_o,
	output logic                  done_o
);
	import intra_pkg::*;

	abs_t [15:0]          abs_q;
	blk_req_t             req_d;
	logic [BIT_DEPTH+8:0] abs_sum;
	blk_cost_t            blk_cost;
	mb_cost_t             acc_q;
	mb_cost_t             mode_cost;
	mb_cost_t             cand_cost;
	logic                 mode_avail;
	logic                 take_cand;
	pred_mode_t           best_mode_q;
	mb_cost_t             best_cost_q;
	pred_mode_t           new_mode;
	mb_cost_t             new_cost;

	// Stage 1, absolute values travel with the delayed request
	always_ff @(posedge clk) begin
		for (int i = 0; i < 16; i++) begin
			abs_q[i] <= abs_t'(coef_i[i][BIT_DEPTH+4] ? -coef_i[i] : coef_i[i]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_d <= '0;
		end else begin
			req_d <= req_i;
		end
	end

	always_comb begin
		abs_sum = '0;
		for (int i = 0; i < 16; i++) begin
			abs_sum += abs_q[i];
		end
		blk_cost  = blk_cost_t'(abs_sum >> 1);
		mode_cost = acc_q + blk_cost;
		case (req_d.mode)
			MODE_V:  mode_avail = avail_t_i;
			MODE_H:  mode_avail = avail_l_i;
			default: mode_avail = 1'b1;
		endcase
		cand_cost = mode_avail ? mode_cost : COST_MAX;
		// Vertical opens the race, later modes must be strictly cheaper
		take_cand = (req_d.mode == MODE_V) || (cand_cost < best_cost_q);
		new_mode  = take_cand ? req_d.mode : best_mode_q;
		new_cost  = take_cand ? cand_cost : best_cost_q;
	end

	//----------------------------------------------------------------------
	// Stage 2, accumulate and select
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_q       <= '0;
			best_mode_q <= MODE_V;
			best_cost_q <= '0;
			mode_o      <= MODE_V;
			cost_o      <= '0;
			done_o      <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (req_d.valid) begin
				if (req_d.last) begin
					acc_q       <= '0;
					best_mode_q <= new_mode;
					best_cost_q <= new_cost;
					if (req_d.mode == MODE_DC) begin
						mode_o <= new_mode;
						cost_o <= new_cost;
						done_o <= 1'b1;
					end
				end else begin
					acc_q <= mode_cost;
				end
			end
		end
	end

endmodule

// ==== intra16_ctrl.sv ====
// Intra 16x16 sequencer that steps three modes over sixteen 4x4 blocks after a start pulse
`timescale 1ns/1ns

module intra16_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start_i,
	output intra_pkg::blk_req_t req_o,
	output logic                busy_o
);
	import intra_pkg::*;

	typedef enum logic {
		IDLE,
		RUN
	} state_t;

	// Block 14 sets last for the following request
	localparam blk_num_t NUM_PRE_LAST = blk_num_t'(BLK_PER_MB - 2);

	state_t   state;
	blk_req_t req_q;

	//----------------------------------------------------------------------
	// Mode and block counters live in the request register
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			req_q <= '0;
		end else begin
			case (state)
				IDLE: begin
					// Start only counts while idle
					if (start_i) begin
						state       <= RUN;
						req_q.valid <= 1'b1;
						req_q.mode  <= MODE_V;
						req_q.num   <= '0;
						req_q.last  <= 1'b0;
					end
				end
				RUN: begin
					if (req_q.last && req_q.mode == MODE_DC) begin
						// Keep num so blk_num_o holds while idle
						state       <= IDLE;
						req_q.valid <= 1'b0;
						req_q.last  <= 1'b0;
					end else begin
						req_q.num  <= req_q.num + 1'b1;
						req_q.last <= (req_q.num == NUM_PRE_LAST);
						if (req_q.last) begin
							req_q.mode <= pred_mode_t'(req_q.mode + 2'd1);
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign req_o  = req_q;
	assign busy_o = (state == RUN);

endmodule

// ==== intra16_dc.sv ====
// Intra 16x16 DC predictor that latches the rounded mean of the available neighbours at start
`timescale 1ns/1ns

module intra16_dc (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start_i,
	input  intra_pkg::ref_ctx_t ref_i,
	output intra_pkg::pixel_t   dc_o
);
	import intra_pkg::*;

	logic [BIT_DEPTH+3:0] sum_t;
	logic [BIT_DEPTH+3:0] sum_l;
	logic [BIT_DEPTH+4:0] sum_tl;
	pixel_t               dc_new;
	pixel_t               dc_q;

	always_comb begin
		sum_t = '0;
		sum_l = '0;
		for (int i = 0; i < 16; i++) begin
			sum_t += ref_i.top[i];
			sum_l += ref_i.left[i];
		end
		sum_tl = {1'b0, sum_t} + {1'b0, sum_l};

		// Rounded mean of 32 or 16 pixels
		case ({ref_i.avail_t, ref_i.avail_l})
			2'b11:   dc_new = pixel_t'((sum_tl + 13'd16) >> 5);
			2'b10:   dc_new = pixel_t'((sum_t + 12'd8) >> 4);
			2'b01:   dc_new = pixel_t'((sum_l + 12'd8) >> 4);
			default: dc_new = pixel_t'(DC_DEFAULT);
		endcase
	end

	// One value serves all sixteen DC blocks
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dc_q <= pixel_t'(DC_DEFAULT);
		end else if (start_i) begin
			dc_q <= dc_new;
		end
	end

	assign dc_o = dc_q;

endmodule

// ==== intra16_pe.sv ====
// Intra 16x16 prediction element that builds the 4x4 prediction and its residual
`timescale 1ns/1ns

module intra16_pe (
	input  intra_pkg::blk_req_t req_i,
	input  intra_pkg::ref_ctx_t ref_i,
	input  intra_pkg::pixel_t   dc_i,
	input  intra_pkg::pix_blk_t ori_blk_i,
	output intra_pkg::res_blk_t res_o
);
	import intra_pkg::*;

	pix_blk_t pred;
	blk_num_t ref_idx_v;
	blk_num_t ref_idx_h;

	//----------------------------------------------------------------------
	// Prediction
	//----------------------------------------------------------------------
	// Pixel i sits at row i[3:2] and column i[1:0] of the block
	always_comb begin
		ref_idx_v = '0;
		ref_idx_h = '0;
		for (int i = 0; i < 16; i++) begin
			// Column x of block column c reads top[4c + x]
			ref_idx_v = {req_i.num[1:0], i[1:0]};
			// Row y of block row r reads left[4r + y]
			ref_idx_h = {req_i.num[3:2], i[3:2]};
			case (req_i.mode)
				MODE_V:  pred[i] = ref_i.top[ref_idx_v];
				MODE_H:  pred[i] = ref_i.left[ref_idx_h];
				default: pred[i] = dc_i;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// Residual
	//----------------------------------------------------------------------
	// Formed for unavailable modes too, the cost unit masks them
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			res_o[i] = resid_t'({1'b0, ori_blk_i[i]}) - resid_t'({1'b0, pred[i]});
		end
	end

endmodule

// ==== intra16_properties.sv ====
// Concurrent checks on the start, busy, done and block number timing of the mode decision
`timescale 1ns/1ns

module intra16_properties (
	input logic                clk,
	input logic                rst_n,
	input logic                start_i,
	input logic                busy_i,
	input logic                done_i,
	input intra_pkg::blk_num_t blk_num_i
);

	//----------------------------------------------------------------------
	// Result timing
	//----------------------------------------------------------------------
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done_i |=> !done_i)
		else $error("done_o high on two consecutive cycles");

	// Done is registered on edge 49 and seen at the following edge
	a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(start_i && !busy_i) |-> ##49 !done_i ##1 done_i)
		else $error("done_o not 49 edges after an accepted start");

	a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
		!(busy_i && done_i))
		else $error("busy_o and done_o high together");

	// Block number parks while idle
	a_num_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!busy_i |-> $stable(blk_num_i))
		else $error("blk_num_o moved while idle");

endmodule

// ==== intra16_top.sv ====
// Intra 16x16 luma mode decision top joining sequencer, predictors, transform and cost
`timescale 1ns/1ns

module intra16_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_i,
	input  intra_pkg::ref_ctx_t   ref_i,
	input  intra_pkg::pix_blk_t   ori_blk_i,
	output intra_pkg::blk_num_t   blk_num_o,
	output logic                  busy_o,
	output logic                  done_o,
	output intra_pkg::pred_mode_t mode_o,
	output intra_pkg::mb_cost_t   cost_o
);
	import intra_pkg::*;

	blk_req_t  req;
	pixel_t    dc;
	res_blk_t  res;
	coef_blk_t coef;

	// Original block is read with the current request number
	assign blk_num_o = req.num;

	//----------------------------------------------------------------------
	// Control and prediction
	//----------------------------------------------------------------------
	intra16_ctrl u_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.start_i (start_i),
		.req_o   (req),
		.busy_o  (busy_o)
	);

	intra16_dc u_dc (
		.clk     (clk),
		.rst_n   (rst_n),
		.start_i (start_i),
		.ref_i   (ref_i),
		.dc_o    (dc)
	);

	intra16_pe u_pe (
		.req_i     (req),
		.ref_i     (ref_i),
		.dc_i      (dc),
		.ori_blk_i (ori_blk_i),
		.res_o     (res)
	);

	//----------------------------------------------------------------------
	// Transform and cost
	//----------------------------------------------------------------------
	intra_hadamard4x4 u_hadamard (
		.res_i  (res),
		.coef_o (coef)
	);

	intra16_cost u_cost (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_i     (req),
		.avail_t_i (ref_i.avail_t),
		.avail_l_i (ref_i.avail_l),
		.coef_i    (coef),
		.mode_o    (mode_o),
		.cost_o    (cost_o),
		.done_o    (done_o)
	);

endmodule

// ==== intra_hadamard4x4.sv ====
// Combinational unnormalised 4x4 Hadamard transform of a residual block
`timescale 1ns/1ns

module intra_hadamard4x4 (
	input  intra_pkg::res_blk_t  res_i,
	output intra_pkg::coef_blk_t coef_o
);
	import intra_pkg::*;

	typedef coef_t [3:0] coef_row_t;

	// Four point butterfly, every output a +-1 sum of all inputs
	function automatic coef_row_t bfly4(input coef_row_t x);
		coef_row_t m;
		coef_row_t y;
		m[0] = x[0] + x[3];
		m[1] = x[1] + x[2];
		m[2] = x[1] - x[2];
		m[3] = x[0] - x[3];
		y[0] = m[0] + m[1];
		y[1] = m[3] + m[2];
		y[2] = m[0] - m[1];
		y[3] = m[3] - m[2];
		return y;
	endfunction

	coef_blk_t hor;
	coef_row_t row_in;
	coef_row_t row_out;
	coef_row_t col_in;
	coef_row_t col_out;

	//----------------------------------------------------------------------
	// Horizontal stage, one butterfly per row
	//----------------------------------------------------------------------
	always_comb begin
		for (int y = 0; y < 4; y++) begin
			for (int x = 0; x < 4; x++) begin
				row_in[x] = {{4{res_i[4*y+x][BIT_DEPTH]}}, res_i[4*y+x]};
			end
			row_out = bfly4(row_in);
			for (int x = 0; x < 4; x++) begin
				hor[4*y+x] = row_out[x];
			end
		end
	end

	//----------------------------------------------------------------------
	// Vertical stage, one butterfly per column
	//----------------------------------------------------------------------
	always_comb begin
		for (int x = 0; x < 4; x++) begin
			for (int y = 0; y < 4; y++) begin
				col_in[y] = hor[4*y+x];
			end
			col_out = bfly4(col_in);
			for (int y = 0; y < 4; y++) begin
				coef_o[4*y+x] = col_out[y];
			end
		end
	end

endmodule

// ==== intra_pkg.sv ====
// Shared widths, pixel and cost types, mode enum and structs of the Intra 16x16 luma mode decision
package intra_pkg;

	//----------------------------------------------------------------------
	// Constants
	//----------------------------------------------------------------------
	localparam int BIT_DEPTH  = 8;
	localparam int BLK_PER_MB = 16;
	localparam int DC_DEFAULT = 128;

	//----------------------------------------------------------------------
	// Scalar types
	//----------------------------------------------------------------------
	typedef logic        [BIT_DEPTH-1:0]  pixel_t;
	typedef logic signed [BIT_DEPTH:0]    resid_t;
	typedef logic signed [BIT_DEPTH+4:0]  coef_t;
	typedef logic        [BIT_DEPTH+3:0]  abs_t;
	typedef logic        [BIT_DEPTH+7:0]  blk_cost_t;
	typedef logic        [BIT_DEPTH+11:0] mb_cost_t;
	// Upper two bits are the block row, lower two the block column
	typedef logic        [3:0]            blk_num_t;

	// All ones in 20 bits (1048575)
	localparam mb_cost_t COST_MAX = '1;

	typedef enum logic [1:0] {
		MODE_V  = 2'd0,
		MODE_H  = 2'd1,
		MODE_DC = 2'd2
	} pred_mode_t;

	//----------------------------------------------------------------------
	// Arrays, index 0 is leftmost or uppermost
	//----------------------------------------------------------------------
	typedef pixel_t [15:0] ref_line_t;
	typedef pixel_t [15:0] pix_blk_t;
	typedef resid_t [15:0] res_blk_t;
	typedef coef_t  [15:0] coef_blk_t;

	// Neighbour context of one macroblock
	typedef struct packed {
		ref_line_t top;
		ref_line_t left;
		logic      avail_t;
		logic      avail_l;
	} ref_ctx_t;

	// One 4x4 block request, last marks block 15 of a mode
	typedef struct packed {
		logic       valid;
		pred_mode_t mode;
		blk_num_t   num;
		logic       last;
	} blk_req_t;

endpackage

// ==== project.f ====
intra_pkg.sv
intra16_ctrl.sv
intra16_dc.sv
intra16_pe.sv
intra_hadamard4x4.sv
intra16_cost.sv
intra16_top.sv
intra16_properties.sv
tb_intra16.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the Intra 16x16 mode decision testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_intra16 -f project.f

./obj_dir/Vtb_intra16

// ==== tb_intra16.sv ====
// Testbench for the Intra 16x16 luma mode decision, table driven against a software model
`timescale 1ns/1ns

module tb_intra16;
	import intra_pkg::*;

	localparam int NUM_ROWS = 8;
	localparam int TIMEOUT  = 200;

	typedef enum logic [1:0] {PAT_FLAT, PAT_VSTRIPE, PAT_HSTRIPE, PAT_RANDOM} pattern_t;

	typedef struct packed {
		logic [127:0] name;
		pattern_t     pattern;
		logic         avail_t;
		logic         avail_l;
		logic         fix_mode;
		pred_mode_t   exp_mode;
		logic         fix_cost;
		mb_cost_t     exp_cost;
		logic         twice;
	} test_row_t;

	// Name, pattern, avail top and left, fixed mode flag and mode, fixed cost flag and cost,
	// second start during busy
	localparam test_row_t TABLE [NUM_ROWS] = '{
		'{"flat_both",    PAT_FLAT,    1'b1, 1'b1, 1'b1, MODE_V,  1'b1, 20'd0, 1'b0},
		'{"vert_stripes", PAT_VSTRIPE, 1'b1, 1'b1, 1'b1, MODE_V,  1'b1, 20'd0, 1'b0},
		'{"horz_stripes", PAT_HSTRIPE, 1'b1, 1'b1, 1'b1, MODE_H,  1'b1, 20'd0, 1'b0},
		'{"rand_none",    PAT_RANDOM,  1'b0, 1'b0, 1'b1, MODE_DC, 1'b0, 20'd0, 1'b0},
		'{"rand_top",     PAT_RANDOM,  1'b1, 1'b0, 1'b0, MODE_V,  1'b0, 20'd0, 1'b0},
		'{"rand_left",    PAT_RANDOM,  1'b0, 1'b1, 1'b0, MODE_V,  1'b0, 20'd0, 1'b0},
		'{"rand_both",    PAT_RANDOM,  1'b1, 1'b1, 1'b0, MODE_V,  1'b0, 20'd0, 1'b0},
		'{"double_start", PAT_RANDOM,  1'b1, 1'b1, 1'b0, MODE_V,  1'b0, 20'd0, 1'b1}
	};

	logic        clk = 1'b0;
	logic        rst_n;
	logic        start;
	ref_ctx_t    ref_ctx;
	pix_blk_t    ori_blk;
	blk_num_t    blk_num;
	logic        busy;
	logic        done;
	pred_mode_t  mode;
	mb_cost_t    cost;
	pixel_t      img [16][16];
	pixel_t      top_ref [16];
	pixel_t      left_ref [16];
	logic [31:0] lfsr = 32'hdf85;

	always #4 clk = ~clk;

	intra16_top UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.start_i   (start),
		.ref_i     (ref_ctx),
		.ori_blk_i (ori_blk),
		.blk_num_o (blk_num),
		.busy_o    (busy),
		.done_o    (done),
		.mode_o    (mode),
		.cost_o    (cost)
	);

	bind intra16_top intra16_properties u_props (
		.clk       (clk),
		.rst_n     (rst_n),
		.start_i   (start_i),
		.busy_i    (busy_o),
		.done_i    (done_o),
		.blk_num_i (blk_num_o)
	);

	// Pixel memory read by block number
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			ori_blk[i] = img[4 * blk_num[3:2] + i / 4][4 * blk_num[1:0] + i % 4];
		end
	end

	//----------------------------------------------------------------------
	// Random source and reference model
	//----------------------------------------------------------------------
	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_pixel(output pixel_t p);
		for (int b = 0; b < BIT_DEPTH; b++) begin
			lfsr = lfsr_next(lfsr);
			p[b] = lfsr[0];
		end
	endtask

	// Entry of the Sylvester ordered Hadamard matrix
	// Row order leaves the absolute sum unchanged
	function automatic int hsign(input int a, input int b);
		return ($countones(a & b) % 2 == 1) ? -1 : 1;
	endfunction

	function automatic int model_dc(input logic at, input logic al);
		int st;
		int sl;
		st = 0;
		sl = 0;
		for (int i = 0; i < 16; i++) begin
			st += int'(top_ref[i]);
			sl += int'(left_ref[i]);
		end
		return (at && al) ? (st + sl + 16) / 32 : at ? (st + 8) / 16 :
			al ? (sl + 8) / 16 : DC_DEFAULT;
	endfunction

	function automatic mb_cost_t model_cost(input pred_mode_t m, input int dcv);
		int r [4][4];
		int pred;
		int coef;
		int abs_sum;
		int total;
		total = 0;
		for (int by = 0; by < 4; by++) begin
			for (int bx = 0; bx < 4; bx++) begin
				for (int y = 0; y < 4; y++) begin
					for (int x = 0; x < 4; x++) begin
						pred = (m == MODE_V) ? int'(top_ref[4 * bx + x]) :
							(m == MODE_H) ? int'(left_ref[4 * by + y]) : dcv;
						r[y][x] = int'(img[4 * by + y][4 * bx + x]) - pred;
					end
				end
				abs_sum = 0;
				for (int u = 0; u < 16; u++) begin
					coef = 0;
					for (int k = 0; k < 16; k++) begin
						coef += hsign(u / 4, k / 4) * hsign(u % 4, k % 4) * r[k / 4][k % 4];
					end
					abs_sum += (coef < 0) ? -coef : coef;
				end
				total += abs_sum / 2;
			end
		end
		return mb_cost_t'(total);
	endfunction

	task automatic model_result(input logic at, input logic al,
			output pred_mode_t best_mode, output mb_cost_t best_cost);
		mb_cost_t cost_h;
		mb_cost_t cost_dc;
		int       dcv;
		dcv       = model_dc(at, al);
		best_cost = at ? model_cost(MODE_V, dcv) : COST_MAX;
		cost_h    = al ? model_cost(MODE_H, dcv) : COST_MAX;
		cost_dc   = model_cost(MODE_DC, dcv);
		best_mode = MODE_V;
		// Ties keep the earlier mode
		if (cost_h < best_cost) begin
			best_mode = MODE_H;
			best_cost = cost_h;
		end
		if (cost_dc < best_cost) begin
			best_mode = MODE_DC;
			best_cost = cost_dc;
		end
	endtask

	//----------------------------------------------------------------------
	// Stimulus and checks
	//----------------------------------------------------------------------
	task automatic check_value(input string name, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR %s %s: expected %0d, actual %0d", name, what, exp, act);
			$display("Done: errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic wait_done(input string name);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < TIMEOUT) begin
			@(negedge clk);
			seen = done;
			n++;
		end
		if (!seen) begin
			$display("Test %s: done_o did not rise within %0d cycles", name, TIMEOUT);
			$display("Done: errors found");
			$fatal(1, "timeout waiting for done_o");
		end
	endtask

	task automatic start_pulse();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic fill_image(input pattern_t pat);
		pixel_t flat;
		rand_pixel(flat);
		for (int i = 0; i < 16; i++) begin
			rand_pixel(top_ref[i]);
			rand_pixel(left_ref[i]);
		end
		for (int y = 0; y < 16; y++) begin
			for (int x = 0; x < 16; x++) begin
				case (pat)
					PAT_FLAT:    img[y][x] = flat;
					PAT_VSTRIPE: img[y][x] = top_ref[x];
					PAT_HSTRIPE: img[y][x] = left_ref[y];
					default:     rand_pixel(img[y][x]);
				endcase
			end
			if (pat == PAT_FLAT) begin
				top_ref[y]  = flat;
				left_ref[y] = flat;
			end
		end
	endtask

	task automatic run_row(input int idx);
		test_row_t  row;
		string      name;
		pred_mode_t m_mode;
		mb_cost_t   m_cost;
		ref_ctx_t   ctx;
		row  = TABLE[idx];
		name = string'(row.name);
		fill_image(row.pattern);
		for (int i = 0; i < 16; i++) begin
			ctx.top[i]  = top_ref[i];
			ctx.left[i] = left_ref[i];
		end
		ctx.avail_t = row.avail_t;
		ctx.avail_l = row.avail_l;
		model_result(row.avail_t, row.avail_l, m_mode, m_cost);
		@(posedge clk);
		ref_ctx <= ctx;
		start_pulse();
		if (row.twice) begin
			repeat (5) @(posedge clk);
			@(negedge clk);
			check_value(name, "busy before second start", 32'd1, 32'(busy));
			start_pulse();
		end
		wait_done(name);
		check_value(name, "mode", 32'(row.fix_mode ? row.exp_mode : m_mode), 32'(mode));
		check_value(name, "cost", 32'(row.fix_cost ? row.exp_cost : m_cost), 32'(cost));
		// A second run would end well inside this window
		if (row.twice) begin
			for (int n = 0; n < 60; n++) begin
				@(negedge clk);
				check_value(name, "extra done", 32'd0, 32'(done));
			end
		end
	endtask

	initial begin
		rst_n   = 1'b0;
		start   = 1'b0;
		ref_ctx = '0;
		// Address pattern until the first test fills the image
		for (int y = 0; y < 16; y++) begin
			for (int x = 0; x < 16; x++) begin
				img[y][x] = pixel_t'(16 * y + x);
			end
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("reset", "busy", 32'd0, 32'(busy));
		check_value("reset", "done", 32'd0, 32'(done));
		check_value("reset", "mode", 32'd0, 32'(mode));
		check_value("reset", "cost", 32'd0, 32'(cost));
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i);
		end
		$display("Done: no errors");
		$finish;
	end

endmodule
